/* include/qpu_settings.svh */
// Width, register count and queue depth settings for the QPU execution stage
`ifndef QPU_SETTINGS_SVH
`define QPU_SETTINGS_SVH

////////////////////
// Classical datapath
`define QPU_XLEN              32  // Classical word
`define QPU_RFIDX_WIDTH       4
`define QPU_RF_NUM            16
`define QPU_IMM_WIDTH         16  // Immediate field in the instruction

////////////////////
// Timing and events
`define QPU_TIME_WIDTH        32
`define QPU_EVENT_NUM         4   // One mask bit per channel
`define QPU_EVENT_WIRE_WIDTH  16

////////////////////
// Event queue
`define QPU_EVQ_DEPTH         8
`define QPU_EVQ_PTR_WIDTH     3   // Must cover QPU_EVQ_DEPTH entries

`endif

/* verilog/qpu_pkg.sv */
// Opcode and width types shared by the QPU execution stage
`default_nettype none

`include "qpu_settings.svh"

package qpu_pkg;

  ////////////////////
  // Instruction opcodes
  typedef enum logic [3:0] {
    OP_NOP   = 4'd0,
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_ADDI  = 4'd3,  // rd = rs1 + sign-extended imm
    OP_WAIT  = 4'd4,  // Advance timing register by imm
    OP_EVENT = 4'd5   // Queue an event at the current time
  } opcode_e;

  ////////////////////
  // Datapath widths
  typedef logic [`QPU_XLEN-1:0]             word_t;
  typedef logic [`QPU_RFIDX_WIDTH-1:0]      rf_idx_t;
  typedef logic [`QPU_TIME_WIDTH-1:0]       time_t;

  // Event entry fields
  typedef logic [`QPU_EVENT_NUM-1:0]        evt_mask_t;
  typedef logic [`QPU_EVENT_WIRE_WIDTH-1:0] evt_data_t;

endpackage

`default_nettype wire

/* verilog/qpu_exu_decode.sv */
// Instruction decoder that splits the word into opcode, register indices and immediate
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module qpu_exu_decode (
  input  wire qpu_pkg::word_t i_instr,
  output qpu_pkg::opcode_e    o_op,
  output qpu_pkg::rf_idx_t    o_rd_idx,
  output qpu_pkg::rf_idx_t    o_rs1_idx,
  output qpu_pkg::rf_idx_t    o_rs2_idx,
  output qpu_pkg::word_t      o_imm
);

  // Field positions with opcode on top and immediate at the bottom
  localparam int OPC_WIDTH = $bits(qpu_pkg::opcode_e);
  localparam int OPC_LSB   = `QPU_XLEN - OPC_WIDTH;
  localparam int RD_LSB    = OPC_LSB - `QPU_RFIDX_WIDTH;
  localparam int RS1_LSB   = RD_LSB - `QPU_RFIDX_WIDTH;
  localparam int RS2_LSB   = RS1_LSB - `QPU_RFIDX_WIDTH;
  localparam int EXT_WIDTH = `QPU_XLEN - `QPU_IMM_WIDTH;

  logic [OPC_WIDTH-1:0]      opc_field;
  logic [`QPU_IMM_WIDTH-1:0] imm_field;

  assign opc_field = i_instr[OPC_LSB +: OPC_WIDTH];
  assign imm_field = i_instr[`QPU_IMM_WIDTH-1:0];

  assign o_rd_idx  = i_instr[RD_LSB +: `QPU_RFIDX_WIDTH];
  assign o_rs1_idx = i_instr[RS1_LSB +: `QPU_RFIDX_WIDTH];
  assign o_rs2_idx = i_instr[RS2_LSB +: `QPU_RFIDX_WIDTH];

  ////////////////////
  // Opcode check
  always_comb begin
    case (opc_field)
      qpu_pkg::OP_ADD,
      qpu_pkg::OP_SUB,
      qpu_pkg::OP_ADDI,
      qpu_pkg::OP_WAIT,
      qpu_pkg::OP_EVENT: o_op = qpu_pkg::opcode_e'(opc_field);
      default:           o_op = qpu_pkg::OP_NOP;  // Unknown codes behave as NOP
    endcase
  end

  ////////////////////
  // Immediate extension
  always_comb begin
    if (o_op == qpu_pkg::OP_ADDI) begin
      o_imm = {{EXT_WIDTH{imm_field[`QPU_IMM_WIDTH-1]}}, imm_field};  // Signed offset
    end else begin
      // Wait counts and event masks are unsigned
      o_imm = {{EXT_WIDTH{1'b0}}, imm_field};
    end
  end

endmodule

`default_nettype wire

/* verilog/qpu_exu_regfile.sv */
// Classical register file with hard-wired register 0 and the timing register
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module qpu_exu_regfile (
  input  wire                   clk,
  input  wire                   i_arst_n,
  input  wire qpu_pkg::rf_idx_t i_rs1_idx,
  input  wire qpu_pkg::rf_idx_t i_rs2_idx,
  output qpu_pkg::word_t        o_rs1_data,
  output qpu_pkg::word_t        o_rs2_data,
  input  wire                   i_wen,
  input  wire qpu_pkg::rf_idx_t i_wr_idx,
  input  wire qpu_pkg::word_t   i_wr_data,
  input  wire                   i_time_wen,
  input  wire qpu_pkg::time_t   i_time_data,
  output qpu_pkg::time_t        o_time
);

  qpu_pkg::word_t rf_q [`QPU_RF_NUM];
  qpu_pkg::time_t time_q;  // Time of the next issued event

  ////////////////////
  // Classical registers
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `QPU_RF_NUM; i++) begin
        rf_q[i] <= '0;
      end
    end else if (i_wen && (i_wr_idx != '0)) begin  // Register 0 keeps its reset zero
      rf_q[i_wr_idx] <= i_wr_data;
    end
  end

  // Next instruction reads the written value with no bypass
  assign o_rs1_data = rf_q[i_rs1_idx];
  assign o_rs2_data = rf_q[i_rs2_idx];

  ////////////////////
  // Timing register
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      time_q <= '0;
    end else if (i_time_wen) begin
      time_q <= i_time_data;
    end
  end

  assign o_time = time_q;

endmodule

`default_nettype wire

/* verilog/qpu_exu_alu.sv */
// Execution unit computing register results, the next time value and event entries
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module qpu_exu_alu (
  input  wire                   i_fire,
  input  wire qpu_pkg::opcode_e i_op,
  input  wire qpu_pkg::rf_idx_t i_rd_idx,
  input  wire qpu_pkg::word_t   i_imm,
  input  wire qpu_pkg::word_t   i_rs1_data,
  input  wire qpu_pkg::word_t   i_rs2_data,
  input  wire qpu_pkg::time_t   i_time,
  output logic                  o_wen,
  output qpu_pkg::rf_idx_t      o_wr_idx,
  output qpu_pkg::word_t        o_wr_data,
  output logic                  o_time_wen,
  output qpu_pkg::time_t        o_time_next,
  output logic                  o_evt_push,
  output qpu_pkg::time_t        o_evt_time,
  output qpu_pkg::evt_mask_t    o_evt_mask,
  output qpu_pkg::evt_data_t    o_evt_data
);

  logic           rd_write;  // Opcode writes a classical register
  logic           is_wait;
  logic           is_event;
  qpu_pkg::word_t alu_res;

  ////////////////////
  // Classical result
  always_comb begin
    rd_write = 1'b0;
    alu_res  = '0;
    case (i_op)
      qpu_pkg::OP_ADD: begin
        rd_write = 1'b1;
        alu_res  = i_rs1_data + i_rs2_data;  // Wraps on overflow
      end
      qpu_pkg::OP_SUB: begin
        rd_write = 1'b1;
        alu_res  = i_rs1_data - i_rs2_data;
      end
      qpu_pkg::OP_ADDI: begin
        rd_write = 1'b1;
        alu_res  = i_rs1_data + i_imm;       // imm already sign-extended
      end
      default: begin
        rd_write = 1'b0;
      end
    endcase
  end

  assign o_wen     = i_fire & rd_write;
  assign o_wr_idx  = i_rd_idx;
  assign o_wr_data = alu_res;

  ////////////////////
  // Timing register update
  assign is_wait     = (i_op == qpu_pkg::OP_WAIT);
  assign o_time_wen  = i_fire & is_wait;
  assign o_time_next = i_time + qpu_pkg::time_t'(i_imm);

  ////////////////////
  // Event entry
  assign is_event   = (i_op == qpu_pkg::OP_EVENT);
  assign o_evt_push = i_fire & is_event;
  assign o_evt_time = i_time;  // Stamped with time after earlier waits
  assign o_evt_mask = i_imm[`QPU_EVENT_NUM-1:0];
  assign o_evt_data = i_rs1_data[`QPU_EVENT_WIRE_WIDTH-1:0];

endmodule

`default_nettype wire

/* verilog/qpu_exu_evq.sv */
// Timestamped event queue that releases entries once the trigger clock reaches them
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module qpu_exu_evq (
  input  wire                     clk,
  input  wire                     i_arst_n,
  input  wire                     i_push,
  input  wire qpu_pkg::time_t     i_push_time,
  input  wire qpu_pkg::evt_mask_t i_push_mask,
  input  wire qpu_pkg::evt_data_t i_push_data,
  output logic                    o_full,
  input  wire                     i_trigger,
  input  wire qpu_pkg::time_t     i_trigger_clk,
  output logic                    o_trigger_clk_ena,
  output qpu_pkg::evt_mask_t      o_trigger_valid,
  output qpu_pkg::evt_data_t      o_trigger_data,
  output logic                    o_empty
);

  localparam int               DEPTH    = `QPU_EVQ_DEPTH;
  localparam int               PTR_W    = `QPU_EVQ_PTR_WIDTH;
  localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(DEPTH - 1);

  qpu_pkg::time_t     time_mem [DEPTH];
  qpu_pkg::evt_mask_t mask_mem [DEPTH];
  qpu_pkg::evt_data_t data_mem [DEPTH];

  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [PTR_W:0]     count_q;
  qpu_pkg::time_t     head_time;
  qpu_pkg::evt_mask_t head_mask;
  qpu_pkg::evt_data_t head_data;
  logic               pop;

  // Circular increment that wraps after the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == LAST_IDX) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////
  // Entry storage
  always_ff @(posedge clk) begin
    if (i_push) begin
      time_mem[wr_ptr_q] <= i_push_time;
      mask_mem[wr_ptr_q] <= i_push_mask;
      data_mem[wr_ptr_q] <= i_push_data;
    end
  end

  assign head_time = time_mem[rd_ptr_q];
  assign head_mask = mask_mem[rd_ptr_q];
  assign head_data = data_mem[rd_ptr_q];

  assign o_full  = (count_q == FULL_CNT);
  assign o_empty = (count_q == '0);

  // Head is due once the outside clock has caught up with it
  assign pop               = i_trigger & ~o_empty & (head_time <= i_trigger_clk);
  assign o_trigger_clk_ena = i_trigger & ~o_empty;

  ////////////////////
  // Pointers and count
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({i_push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle or push and pop together
      endcase
    end
  end

  ////////////////////
  // Trigger outputs give a one-cycle pulse per released entry
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_trigger_valid <= '0;
      o_trigger_data  <= '0;
    end else if (pop) begin
      o_trigger_valid <= head_mask;  // Mask zero drops the entry quietly
      o_trigger_data  <= (head_mask != '0) ? head_data : '0;
    end else begin
      o_trigger_valid <= '0;
      o_trigger_data  <= '0;
    end
  end

endmodule

`default_nettype wire

/* verilog/qpu_exu.sv */
// Top of the QPU execution stage with the instruction handshake and unit wiring
`timescale 1ns/1ps
`default_nettype none

module qpu_exu (
  input  wire                 clk,
  input  wire                 i_arst_n,
  input  wire                 i_valid,
  output logic                o_ready,
  input  wire qpu_pkg::word_t i_ir,
  input  wire                 i_trigger,
  input  wire qpu_pkg::time_t i_trigger_clk,
  output logic                o_trigger_clk_ena,
  output qpu_pkg::evt_mask_t  o_trigger_valid,
  output qpu_pkg::evt_data_t  o_trigger_data,
  output logic                o_exu_active
);

  qpu_pkg::opcode_e   dec_op;
  qpu_pkg::rf_idx_t   dec_rd_idx;
  qpu_pkg::rf_idx_t   dec_rs1_idx;
  qpu_pkg::rf_idx_t   dec_rs2_idx;
  qpu_pkg::word_t     dec_imm;

  qpu_pkg::word_t     rf_rs1_data;
  qpu_pkg::word_t     rf_rs2_data;
  qpu_pkg::time_t     rf_time;

  logic               alu_wen;
  qpu_pkg::rf_idx_t   alu_wr_idx;
  qpu_pkg::word_t     alu_wr_data;
  logic               alu_time_wen;
  qpu_pkg::time_t     alu_time_next;
  logic               alu_evt_push;
  qpu_pkg::time_t     alu_evt_time;
  qpu_pkg::evt_mask_t alu_evt_mask;
  qpu_pkg::evt_data_t alu_evt_data;

  logic               evq_full;
  logic               evq_empty;
  logic               fire;  // Instruction accepted this cycle

  ////////////////////
  // Handshake
  assign o_ready      = ~evq_full;  // Only a full queue can stall
  assign fire         = i_valid & o_ready;
  assign o_exu_active = ~evq_empty | i_valid;

  qpu_exu_decode u_decode (
    .i_instr   (i_ir       ),
    .o_op      (dec_op     ),
    .o_rd_idx  (dec_rd_idx ),
    .o_rs1_idx (dec_rs1_idx),
    .o_rs2_idx (dec_rs2_idx),
    .o_imm     (dec_imm    )
  );

  qpu_exu_regfile u_regfile (
    .clk         (clk          ),
    .i_arst_n    (i_arst_n     ),
    .i_rs1_idx   (dec_rs1_idx  ),
    .i_rs2_idx   (dec_rs2_idx  ),
    .o_rs1_data  (rf_rs1_data  ),
    .o_rs2_data  (rf_rs2_data  ),
    .i_wen       (alu_wen      ),
    .i_wr_idx    (alu_wr_idx   ),
    .i_wr_data   (alu_wr_data  ),
    .i_time_wen  (alu_time_wen ),
    .i_time_data (alu_time_next),
    .o_time      (rf_time      )
  );

  qpu_exu_alu u_alu (
    .i_fire      (fire         ),
    .i_op        (dec_op       ),
    .i_rd_idx    (dec_rd_idx   ),
    .i_imm       (dec_imm      ),
    .i_rs1_data  (rf_rs1_data  ),
    .i_rs2_data  (rf_rs2_data  ),
    .i_time      (rf_time      ),
    .o_wen       (alu_wen      ),
    .o_wr_idx    (alu_wr_idx   ),
    .o_wr_data   (alu_wr_data  ),
    .o_time_wen  (alu_time_wen ),
    .o_time_next (alu_time_next),
    .o_evt_push  (alu_evt_push ),
    .o_evt_time  (alu_evt_time ),
    .o_evt_mask  (alu_evt_mask ),
    .o_evt_data  (alu_evt_data )
  );

  qpu_exu_evq u_evq (
    .clk               (clk              ),
    .i_arst_n          (i_arst_n         ),
    .i_push            (alu_evt_push     ),
    .i_push_time       (alu_evt_time     ),
    .i_push_mask       (alu_evt_mask     ),
    .i_push_data       (alu_evt_data     ),
    .o_full            (evq_full         ),
    .i_trigger         (i_trigger        ),
    .i_trigger_clk     (i_trigger_clk    ),
    .o_trigger_clk_ena (o_trigger_clk_ena),
    .o_trigger_valid   (o_trigger_valid  ),
    .o_trigger_data    (o_trigger_data   ),
    .o_empty           (evq_empty        )
  );

endmodule

`default_nettype wire

/* verif/tb_qpu_exu.sv */
// Testbench for the QPU execution stage with random instructions checked against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "qpu_settings.svh"

module tb_qpu_exu;

  localparam int NUM_TESTS      = 5;
  localparam int INSTR_PER_TEST = 32;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * INSTR_PER_TEST * 64;
  localparam int MASK_MAX       = (1 << `QPU_EVENT_NUM) - 1;

  logic               clk = 1'b0;
  logic               i_arst_n;
  logic               i_valid;
  logic               o_ready;
  qpu_pkg::word_t     i_ir;
  logic               i_trigger;
  qpu_pkg::time_t     i_trigger_clk;  // Trigger clock kept by the testbench
  logic               o_trigger_clk_ena;
  qpu_pkg::evt_mask_t o_trigger_valid;
  qpu_pkg::evt_data_t o_trigger_data;
  logic               o_exu_active;

  // Reference model
  qpu_pkg::word_t     model_rf [`QPU_RF_NUM];
  qpu_pkg::time_t     model_time;
  qpu_pkg::time_t     exp_time_q [$];
  qpu_pkg::evt_mask_t exp_mask_q [$];
  qpu_pkg::evt_data_t exp_data_q [$];

  string cur_test;
  int    errors;
  int    checks;
  int    test_err_start;
  int    tests_passed;
  int    tests_failed;
  int    cycles;

  qpu_exu u_dut (
    .clk               (clk              ),
    .i_arst_n          (i_arst_n         ),
    .i_valid           (i_valid          ),
    .o_ready           (o_ready          ),
    .i_ir              (i_ir             ),
    .i_trigger         (i_trigger        ),
    .i_trigger_clk     (i_trigger_clk    ),
    .o_trigger_clk_ena (o_trigger_clk_ena),
    .o_trigger_valid   (o_trigger_valid  ),
    .o_trigger_data    (o_trigger_data   ),
    .o_exu_active      (o_exu_active     )
  );

  initial begin
    forever #4 clk = ~clk;
  end

  // Watchdog on rising edges
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////
  // Compare tasks
  task automatic check_mask(input string name, input qpu_pkg::evt_mask_t exp,
                            input qpu_pkg::evt_mask_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: mask expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input qpu_pkg::evt_data_t exp,
                            input qpu_pkg::evt_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: data expected %h, actual %h", name, exp, act);
    end
  endtask

  // Release may come late but never before the timestamp
  task automatic check_time(input string name, input qpu_pkg::time_t exp,
                            input qpu_pkg::time_t act);
    checks++;
    if ($isunknown(act) || act < exp) begin
      errors++;
      $display("Error %s: release time expected at least %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: flag expected %b, actual %b", name, exp, act);
    end
  endtask

  ////////////////////
  // Model and monitor
  task automatic pop_expected();
    void'(exp_time_q.pop_front());
    void'(exp_mask_q.pop_front());
    void'(exp_data_q.pop_front());
  endtask

  // Pulse seen now was released at the last rising edge
  task automatic check_release();
    if (o_trigger_valid !== '0) begin
      while (exp_mask_q.size() > 0 && exp_mask_q[0] == '0) begin
        pop_expected();  // Silent entries ahead of this one
      end
      if (exp_mask_q.size() == 0) begin
        errors++;
        $display("Test %s: trigger pulse %h with no pending event", cur_test, o_trigger_valid);
      end else begin
        check_mask(cur_test, exp_mask_q[0], o_trigger_valid);
        check_data(cur_test, exp_data_q[0], o_trigger_data);
        check_time(cur_test, exp_time_q[0], i_trigger_clk);
        pop_expected();
      end
    end
  endtask

  task automatic step();
    @(negedge clk);
    check_release();
    if (o_trigger_clk_ena) begin
      i_trigger_clk = i_trigger_clk + 1'b1;
    end
  endtask

  function automatic qpu_pkg::word_t make_instr(input logic [3:0] op,
                                                input qpu_pkg::rf_idx_t rd,
                                                input qpu_pkg::rf_idx_t rs1,
                                                input qpu_pkg::rf_idx_t rs2,
                                                input logic [`QPU_IMM_WIDTH-1:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  task automatic model_accept(input qpu_pkg::word_t ir);
    logic [3:0]                op;
    logic [`QPU_IMM_WIDTH-1:0] imm;
    qpu_pkg::word_t            rs1_val;
    qpu_pkg::word_t            rs2_val;
    op      = ir[31:28];
    imm     = ir[15:0];
    rs1_val = model_rf[ir[23:20]];
    rs2_val = model_rf[ir[19:16]];
    case (op)
      qpu_pkg::OP_ADD:  model_rf[ir[27:24]] = rs1_val + rs2_val;
      qpu_pkg::OP_SUB:  model_rf[ir[27:24]] = rs1_val - rs2_val;
      qpu_pkg::OP_ADDI: model_rf[ir[27:24]] = rs1_val + {{16{imm[15]}}, imm};
      qpu_pkg::OP_WAIT: model_time = model_time + {16'b0, imm};
      qpu_pkg::OP_EVENT: begin
        exp_time_q.push_back(model_time);
        exp_mask_q.push_back(imm[`QPU_EVENT_NUM-1:0]);
        exp_data_q.push_back(rs1_val[`QPU_EVENT_WIRE_WIDTH-1:0]);
      end
      default: ;  // NOP and illegal codes
    endcase
    model_rf[0] = '0;
  endtask

  ////////////////////
  // Stimulus
  task automatic issue(input qpu_pkg::word_t ir);
    i_valid = 1'b1;
    i_ir    = ir;
    while (!o_ready) begin
      step();  // Held until the queue has room
    end
    model_accept(ir);
    step();
    i_valid = 1'b0;
  endtask

  function automatic qpu_pkg::word_t rand_event(input bit zero_ok);
    int unsigned mask;
    mask = (zero_ok && $urandom_range(0, 3) == 0) ? 0 : $urandom_range(1, MASK_MAX);
    return make_instr(qpu_pkg::OP_EVENT, 4'($urandom), 4'($urandom), 4'd0, 16'(mask));
  endfunction

  function automatic qpu_pkg::word_t rand_wait(input int max_ticks);
    return make_instr(qpu_pkg::OP_WAIT, 4'd0, 4'd0, 4'd0, 16'($urandom_range(0, max_ticks)));
  endfunction

  task automatic gen_arith(inout qpu_pkg::rf_idx_t prev_rd, output qpu_pkg::word_t ir);
    logic [3:0]       op;
    qpu_pkg::rf_idx_t rd;
    qpu_pkg::rf_idx_t rs1;
    case ($urandom_range(0, 9))
      0, 1, 2: op = qpu_pkg::OP_ADD;
      3, 4:    op = qpu_pkg::OP_SUB;
      5, 6, 7: op = qpu_pkg::OP_ADDI;
      8:       op = 4'($urandom_range(6, 15));  // Illegal code
      default: op = qpu_pkg::OP_NOP;
    endcase
    rd  = 4'($urandom);  // Register 0 included
    rs1 = $urandom_range(0, 1) ? prev_rd : 4'($urandom);  // Dependent chain
    ir  = make_instr(op, rd, rs1, 4'($urandom), 16'($urandom));
    prev_rd = rd;
  endtask

  // Let the queue empty, then any model entry left must be a silent one
  task automatic drain();
    i_valid   = 1'b0;
    i_trigger = 1'b1;
    step();
    while (o_exu_active) begin
      step();
    end
    while (exp_mask_q.size() > 0) begin
      if (exp_mask_q[0] != '0) begin
        errors++;
        $display("Test %s: event with mask %h was never released", cur_test, exp_mask_q[0]);
      end
      pop_expected();
    end
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    if (errors == test_err_start) begin
      tests_passed++;
      $display("Test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", cur_test, errors - test_err_start);
    end
  endtask

  ////////////////////
  // Test sequence
  initial begin
    qpu_pkg::rf_idx_t prev_rd;
    qpu_pkg::word_t   ir;
    void'($urandom(32'hcf19_3b2a));
    errors        = 0;
    checks        = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    i_arst_n      = 1'b0;
    i_valid       = 1'b0;
    i_ir          = '0;
    i_trigger     = 1'b0;
    i_trigger_clk = '0;
    model_time    = '0;
    prev_rd       = '0;
    for (int r = 0; r < `QPU_RF_NUM; r++) begin
      model_rf[r] = '0;
    end

    begin_test("reset");
    for (int c = 0; c < 6; c++) begin
      if (c == 4) begin
        i_arst_n = 1'b1;  // Released after 4 cycles with a NOP word on i_ir
      end
      step();
      check_mask(cur_test, '0, o_trigger_valid);
      check_bit(cur_test, 1'b0, o_trigger_clk_ena);
      check_bit(cur_test, 1'b1, o_ready);
      check_bit(cur_test, i_valid, o_exu_active);
      i_valid = ~i_valid;
    end
    i_valid = 1'b0;
    end_test();

    begin_test("arith");
    i_trigger = 1'b1;
    for (int n = 0; n < INSTR_PER_TEST - 8; n++) begin
      gen_arith(prev_rd, ir);
      issue(ir);
    end
    repeat (8) issue(rand_event(1'b0));
    drain();
    end_test();

    begin_test("timestamps");
    for (int n = 0; n < INSTR_PER_TEST; n++) begin
      issue($urandom_range(0, 1) ? rand_wait(15) : rand_event(1'b0));
    end
    drain();
    end_test();

    begin_test("order");
    for (int n = 1; n < 8; n++) begin
      issue(make_instr(qpu_pkg::OP_ADDI, 4'(n), 4'd0, 4'd0, 16'($urandom)));
    end
    for (int n = 0; n < INSTR_PER_TEST - 7; n++) begin
      issue(($urandom_range(0, 4) == 0) ? rand_wait(3) : rand_event(1'b1));
    end
    drain();
    end_test();

    begin_test("backpressure");
    i_trigger = 1'b0;
    for (int n = 0; n < `QPU_EVQ_DEPTH; n++) begin
      check_bit(cur_test, 1'b1, o_ready);
      issue(rand_event(1'b0));
    end
    check_bit(cur_test, 1'b0, o_ready);
    ir      = rand_event(1'b0);
    i_valid = 1'b1;
    i_ir    = ir;
    repeat (4) begin
      step();
      check_bit(cur_test, 1'b0, o_ready);
      check_bit(cur_test, 1'b0, o_trigger_clk_ena);  // No clock request without trigger
    end
    i_trigger = 1'b1;
    step();
    check_bit(cur_test, 1'b1, o_trigger_clk_ena);
    issue(ir);  // Same word is accepted once room appears
    repeat (2) issue(rand_event(1'b0));
    drain();
    check_bit(cur_test, 1'b0, o_exu_active);
    check_bit(cur_test, 1'b0, o_trigger_clk_ena);
    end_test();

    $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* qpu_exu.f */
+incdir+include
verilog/qpu_pkg.sv
verilog/qpu_exu_decode.sv
verilog/qpu_exu_regfile.sv
verilog/qpu_exu_alu.sv
verilog/qpu_exu_evq.sv
verilog/qpu_exu.sv
verif/tb_qpu_exu.sv
